// ==== hdl/cnt_pkg.sv ====
// Event counter bank definitions
`default_nettype none

package cnt_pkg;

    ////////////////////
    // Geometry

    // Counter index width and bank depth
    localparam int CNT_AW    = 5;
    localparam int CNT_DEPTH = 32;

    // Counter and add amount widths
    localparam int CNT_W     = 16;
    localparam int AMT_W     = 8;

    // Saturation ceiling for OP_ADD
    localparam logic [CNT_W-1:0] CNT_MAX = '1;

    ////////////////////
    // Encodings

    // Command opcodes
    typedef enum logic {
        OP_ADD   = 1'b0,
        OP_CLEAR = 1'b1
    } op_e;

    // Engine states, sweep first and then normal operation
    typedef enum logic {
        ST_INIT = 1'b0,
        ST_RUN  = 1'b1
    } upd_state_e;

endpackage

`default_nettype wire

// ==== hdl/rmw_if.sv ====
// Read-modify-write interfaces
`timescale 1ns/1ps
`default_nettype none

////////////////////
// Engine to hazard block

interface eng_if;
    import cnt_pkg::*;

    // Read request, issued in cycle t
    logic              re;
    logic [CNT_AW-1:0] ra;
    // Current counter value, valid in t+2
    logic [CNT_W-1:0]  rdd;
    // New counter value, presented in t+3
    logic [CNT_W-1:0]  wrd;

    modport eng (output re, output ra, output wrd, input rdd);
    modport haz (input re, input ra, input wrd, output rdd);
endinterface

////////////////////
// Hazard block to RAM

interface mem_if;
    import cnt_pkg::*;

    // Write port
    logic              we;
    logic [CNT_AW-1:0] wa;
    logic [CNT_W-1:0]  wd;
    // Read port, data two cycles after the request
    logic              re;
    logic [CNT_AW-1:0] ra;
    logic [CNT_W-1:0]  rd;

    modport ctl (output we, output wa, output wd, output re, output ra, input rd);
    modport mem (input we, input wa, input wd, input re, input ra, output rd);
endinterface

`default_nettype wire

// ==== hdl/cnt_ram.sv ====
// Counter storage RAM
`timescale 1ns/1ps
`default_nettype none

module cnt_ram (
    input  wire logic clk,
    input  wire logic rst,
    mem_if.mem        mem
);
    import cnt_pkg::*;

    // Counter words
    logic [CNT_W-1:0]  ram_q [CNT_DEPTH];
    // Registered read address and read word
    logic [CNT_AW-1:0] ra_q;
    logic [CNT_W-1:0]  rd_q;

    ////////////////////
    // Write and read

    always_ff @(posedge clk)
    begin
        // Write lands at the edge that ends the write cycle
        if (mem.we)
        begin
            ram_q[mem.wa] <= mem.wd;
        end
        // Address stage holds its value while no read is issued
        if (mem.re)
        begin
            ra_q <= mem.ra;
        end
        // Data stage gives the second cycle of latency
        rd_q <= ram_q[ra_q];
    end

    assign mem.rd = rd_q;

    ////////////////////
    // Checks

    // The hazard block must keep reads off the word being written
    a_no_rw_collide : assert property (@(posedge clk) disable iff (rst)
        !(mem.re && mem.we && (mem.ra == mem.wa)))
        else $error("cnt_ram: read and write to the same word in one cycle");

endmodule

`default_nettype wire

// ==== hdl/rmw_hazard.sv ====
// Read-modify-write hazard control
`timescale 1ns/1ps
`default_nettype none

module rmw_hazard (
    input  wire logic clk,
    input  wire logic rst,
    eng_if.haz        eng,
    mem_if.ctl        mem
);
    import cnt_pkg::*;

    // Read request pipeline, stage 3 is the write-back
    logic              s1_re;
    logic              s2_re;
    logic              s3_re;
    logic [CNT_AW-1:0] s1_ra;
    logic [CNT_AW-1:0] s2_ra;
    logic [CNT_AW-1:0] s3_ra;

    // Hazard detects
    logic              hit_wr0;
    logic              hit_wr1;
    logic              hit_rd1;

    // Registered forwarding selects
    logic              wr0_q;
    logic              rd1_q;
    logic              fwd_old_q;
    logic              fwd_new_q;

    // Write data copies
    logic [CNT_W-1:0]  wd_d1;
    logic [CNT_W-1:0]  wd_fwd;

    ////////////////////
    // Address pipeline

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s1_re <= 1'b0;
            s2_re <= 1'b0;
            s3_re <= 1'b0;
        end
        else
        begin
            s1_re <= eng.re;
            s2_re <= s1_re;
            s3_re <= s2_re;
        end
    end

    always_ff @(posedge clk)
    begin
        s1_ra <= eng.ra;
        s2_ra <= s1_ra;
        s3_ra <= s2_ra;
    end

    ////////////////////
    // Hazard detection

    // New read against the write in this cycle, RAM read is dropped
    assign hit_wr0 = eng.re & s3_re & (eng.ra == s3_ra);
    // Read one stage in, against the write in this cycle
    assign hit_wr1 = s1_re & s3_re & (s1_ra == s3_ra);
    // New read right behind a read of the same counter
    // Its write-back lands exactly when this read needs data
    assign hit_rd1 = eng.re & s1_re & (eng.ra == s1_ra);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr0_q     <= 1'b0;
            rd1_q     <= 1'b0;
            fwd_old_q <= 1'b0;
            fwd_new_q <= 1'b0;
        end
        else
        begin
            wr0_q     <= hit_wr0;
            rd1_q     <= hit_rd1;
            fwd_old_q <= hit_wr1 | wr0_q;
            fwd_new_q <= rd1_q;
        end
    end

    // Keep the later of the two writes that the RAM read missed
    always_ff @(posedge clk)
    begin
        wd_d1  <= eng.wrd;
        wd_fwd <= hit_wr1 ? eng.wrd : wd_d1;
    end

    ////////////////////
    // Read data select

    // Freshest first: live write data, then saved copy, then RAM
    assign eng.rdd = fwd_new_q ? eng.wrd :
                     fwd_old_q ? wd_fwd  : mem.rd;

    ////////////////////
    // RAM side

    assign mem.re = eng.re & ~hit_wr0;
    assign mem.ra = eng.ra;
    assign mem.we = s3_re;
    assign mem.wa = s3_ra;
    assign mem.wd = eng.wrd;

    // Every write-back belongs to a read three cycles earlier
    a_wr_after_rd : assert property (@(posedge clk) disable iff (rst)
        mem.we |-> $past(eng.re, 3))
        else $error("rmw_hazard: write without a read three cycles before");

endmodule

`default_nettype wire

// ==== hdl/cnt_update.sv ====
// Counter update engine
`timescale 1ns/1ps
`default_nettype none

module cnt_update (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     cmd_valid,
    output logic                          cmd_ready,
    input  wire cnt_pkg::op_e             cmd_op,
    input  wire logic [cnt_pkg::CNT_AW-1:0] cmd_idx,
    input  wire logic [cnt_pkg::AMT_W-1:0]  cmd_amt,
    output logic                          res_valid,
    output logic [cnt_pkg::CNT_AW-1:0]    res_idx,
    output logic [cnt_pkg::CNT_W-1:0]     res_count,
    eng_if.eng                            eng
);
    import cnt_pkg::*;

    upd_state_e        state;
    // Sweep issue flag and index
    logic              init_re;
    logic [CNT_AW-1:0] init_idx;
    logic              accept;

    // Stage 0 is the operation entering the pipeline
    op_e               s0_op;
    logic [AMT_W-1:0]  s0_amt;
    // Stages 1 and 2 while the RAM read is in flight
    op_e               s1_op;
    op_e               s2_op;
    logic [AMT_W-1:0]  s1_amt;
    logic [AMT_W-1:0]  s2_amt;
    logic [CNT_AW-1:0] s1_idx;
    logic [CNT_AW-1:0] s2_idx;
    logic              s1_res;
    logic              s2_res;

    // Update arithmetic
    logic [CNT_W:0]    sum_full;
    logic [CNT_W-1:0]  new_val;
    logic [CNT_W-1:0]  wrd_q;

    ////////////////////
    // Sweep FSM

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= ST_INIT;
            init_re  <= 1'b0;
            init_idx <= '0;
        end
        else
        begin
            case (state)
                ST_INIT:
                begin
                    // First cycle after reset stays idle
                    init_re <= 1'b1;
                    if (init_re)
                    begin
                        init_idx <= init_idx + 1'b1;
                        if (init_idx == CNT_AW'(CNT_DEPTH - 1))
                        begin
                            state   <= ST_RUN;
                            init_re <= 1'b0;
                        end
                    end
                end
                ST_RUN:
                begin
                    state <= ST_RUN;
                end
            endcase
        end
    end

    ////////////////////
    // Issue

    assign cmd_ready = (state == ST_RUN);
    assign accept    = cmd_valid & cmd_ready;

    // Sweep entries are clears of amount zero
    assign eng.re = (state == ST_INIT) ? init_re  : accept;
    assign eng.ra = (state == ST_INIT) ? init_idx : cmd_idx;
    assign s0_op  = (state == ST_INIT) ? OP_CLEAR : cmd_op;
    assign s0_amt = (state == ST_INIT) ? '0       : cmd_amt;

    // Result flags for accepted commands only
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s1_res    <= 1'b0;
            s2_res    <= 1'b0;
            res_valid <= 1'b0;
        end
        else
        begin
            s1_res    <= accept;
            s2_res    <= s1_res;
            res_valid <= s2_res;
        end
    end

    always_ff @(posedge clk)
    begin
        s1_op  <= s0_op;
        s2_op  <= s1_op;
        s1_amt <= s0_amt;
        s2_amt <= s1_amt;
        s1_idx <= eng.ra;
        s2_idx <= s1_idx;
    end

    ////////////////////
    // Update in t+2

    assign sum_full = {1'b0, eng.rdd} + {{(CNT_W + 1 - AMT_W){1'b0}}, s2_amt};

    always_comb
    begin
        if (s2_op == OP_CLEAR)
            new_val = '0;
        else if (sum_full[CNT_W])
            new_val = CNT_MAX;   // carry out means saturate
        else
            new_val = sum_full[CNT_W-1:0];
    end

    // Write-back and result both in t+3
    always_ff @(posedge clk)
    begin
        wrd_q     <= new_val;
        res_idx   <= s2_idx;
        res_count <= (s2_op == OP_CLEAR) ? eng.rdd : new_val;
    end

    assign eng.wrd = wrd_q;

    ////////////////////
    // Checks

    a_no_cmd_in_init : assert property (@(posedge clk) disable iff (rst)
        (state == ST_INIT) |-> !cmd_ready)
        else $error("cnt_update: cmd_ready high during sweep");

endmodule

`default_nettype wire

// ==== hdl/cnt_top.sv ====
// Event counter bank top level
`timescale 1ns/1ps
`default_nettype none

module cnt_top (
    input  wire logic                       clk,
    input  wire logic                       rst,
    // Command side
    input  wire logic                       cmd_valid,
    output logic                            cmd_ready,
    input  wire cnt_pkg::op_e               cmd_op,
    input  wire logic [cnt_pkg::CNT_AW-1:0] cmd_idx,
    input  wire logic [cnt_pkg::AMT_W-1:0]  cmd_amt,
    // Result side, no back-pressure
    output logic                            res_valid,
    output logic [cnt_pkg::CNT_AW-1:0]      res_idx,
    output logic [cnt_pkg::CNT_W-1:0]       res_count
);

    ////////////////////
    // Internal buses

    eng_if eng_bus ();
    mem_if mem_bus ();

    ////////////////////
    // Engine, hazard control, storage

    cnt_update update0 (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_op    (cmd_op),
        .cmd_idx   (cmd_idx),
        .cmd_amt   (cmd_amt),
        .res_valid (res_valid),
        .res_idx   (res_idx),
        .res_count (res_count),
        .eng       (eng_bus.eng)
    );

    rmw_hazard hazard0 (
        .clk (clk),
        .rst (rst),
        .eng (eng_bus.haz),
        .mem (mem_bus.ctl)
    );

    cnt_ram ram0 (
        .clk (clk),
        .rst (rst),
        .mem (mem_bus.mem)
    );

endmodule

`default_nettype wire

// ==== tb/tb_clkgen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst
);

    // 8 ns period
    localparam int HALF_NS    = 4;
    localparam int RST_CYCLES = 3;

    initial
    begin
        clk = 1'b0;
        forever #HALF_NS clk = ~clk;
    end

    // Reset drops just after the third rising edge
    initial
    begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb/tb_cnt_top.sv ====
// Counter bank testbench
`timescale 1ns/1ps
`default_nettype none

module tb_cnt_top;
    import cnt_pkg::*;

    localparam int          MAX_VEC       = 128;
    localparam int          READY_TIMEOUT = 100;
    localparam int          DRAIN_TIMEOUT = 20;
    localparam int          DRIVE_DLY     = 1;
    localparam logic [15:0] LFSR_SEED     = 16'd50930;

    logic              clk;
    logic              rst;
    logic              cmd_valid;
    logic              cmd_ready;
    op_e               cmd_op;
    logic [CNT_AW-1:0] cmd_idx;
    logic [AMT_W-1:0]  cmd_amt;
    logic              res_valid;
    logic [CNT_AW-1:0] res_idx;
    logic [CNT_W-1:0]  res_count;

    // Packed test words, see the data file for the field layout
    logic [47:0]       vec [MAX_VEC];
    int                n_vec;
    logic [15:0]       lfsr;

    // Results still owed by the DUT, oldest first
    logic [CNT_AW-1:0] exp_idx_q [$];
    logic [CNT_W-1:0]  exp_cnt_q [$];
    bit                exp_chk_q [$];
    string             exp_name_q [$];

    int                mismatches   = 0;
    int                other_errors = 0;
    int                timeouts     = 0;
    int                n_checked    = 0;

    tb_clkgen clkgen0 (
        .clk (clk),
        .rst (rst)
    );

    cnt_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_op    (cmd_op),
        .cmd_idx   (cmd_idx),
        .cmd_amt   (cmd_amt),
        .res_valid (res_valid),
        .res_idx   (res_idx),
        .res_count (res_count)
    );

    ////////////////////
    // Stimulus helpers

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // Two fresh bits give 0 to 3 idle cycles
    task automatic random_gap(output int gap);
        gap = 0;
        for (int b = 0; b < 2; b++)
        begin
            lfsr = lfsr_next(lfsr);
            gap  = (gap << 1) | lfsr[0];
        end
    endtask

    // Present one command and hold it until the DUT takes it
    task automatic send_cmd(
        input op_e               op,
        input logic [CNT_AW-1:0] idx,
        input logic [AMT_W-1:0]  amt,
        input logic [CNT_W-1:0]  exp_cnt,
        input bit                check_cnt,
        input string             name
    );
        int waited;
        waited    = 0;
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_idx   = idx;
        cmd_amt   = amt;
        while (!cmd_ready && waited < READY_TIMEOUT)
        begin
            @(posedge clk);
            #DRIVE_DLY;
            waited++;
        end
        if (!cmd_ready)
        begin
            timeouts++;
            $display("Command %s was never accepted", name);
        end
        else
        begin
            exp_idx_q.push_back(idx);
            exp_cnt_q.push_back(exp_cnt);
            exp_chk_q.push_back(check_cnt);
            exp_name_q.push_back(name);
            // Transfer at this edge
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    ////////////////////
    // Result checker

    // Mid-cycle sampling, outputs settled since the rising edge
    always @(negedge clk)
    begin
        string             name;
        logic [CNT_AW-1:0] e_idx;
        logic [CNT_W-1:0]  e_cnt;
        bit                e_chk;
        if (!rst && res_valid)
        begin
            if (exp_cnt_q.size() == 0)
            begin
                other_errors++;
                $display("Result for counter %0d arrived with no command pending", res_idx);
            end
            else
            begin
                name  = exp_name_q.pop_front();
                e_idx = exp_idx_q.pop_front();
                e_cnt = exp_cnt_q.pop_front();
                e_chk = exp_chk_q.pop_front();
                if (res_idx !== e_idx)
                begin
                    mismatches++;
                    $display("Mismatch %s index: expected %0d, actual %0d", name, e_idx, res_idx);
                end
                // Repeated commands carry a count only on the last issue
                if (e_chk && res_count !== e_cnt)
                begin
                    mismatches++;
                    $display("Mismatch %s count: expected %h, actual %h", name, e_cnt, res_count);
                end
                n_checked++;
            end
        end
    end

    ////////////////////
    // Main sequence

    initial
    begin
        int          waited;
        int          gap;
        int          rep;
        logic [47:0] v;
        cmd_valid = 1'b0;
        cmd_op    = OP_ADD;
        cmd_idx   = '0;
        cmd_amt   = '0;
        lfsr      = LFSR_SEED;

        $readmemh("tb/cnt_testdata.txt", vec);
        n_vec = 0;
        while (n_vec < MAX_VEC && !$isunknown(vec[n_vec]))
            n_vec++;
        if (n_vec == 0)
        begin
            other_errors++;
            $display("No test vectors were loaded");
        end

        // Reset, then the clear sweep
        waited = 0;
        @(posedge clk);
        #DRIVE_DLY;
        while ((rst || !cmd_ready) && waited < READY_TIMEOUT)
        begin
            @(posedge clk);
            #DRIVE_DLY;
            waited++;
        end
        if (!cmd_ready)
        begin
            timeouts++;
            $display("cmd_ready never rose after reset");
        end

        for (int i = 0; i < n_vec && timeouts == 0; i++)
        begin
            v   = vec[i];
            rep = v[47:40];
            for (int k = 0; k <= rep && timeouts == 0; k++)
            begin
                if (v[39:36] == 4'hf)
                    random_gap(gap);
                else
                    gap = v[39:36];
                if (gap > 0)
                begin
                    cmd_valid = 1'b0;
                    repeat (gap)
                    begin
                        @(posedge clk);
                        #DRIVE_DLY;
                    end
                end
                send_cmd(op_e'(v[32]), v[24 +: CNT_AW], v[23:16], v[15:0], k == rep,
                         $sformatf("cmd%0d.%0d", i, k));
            end
        end
        cmd_valid = 1'b0;

        // Let the pipeline empty
        waited = 0;
        while (exp_cnt_q.size() != 0 && waited < DRAIN_TIMEOUT)
        begin
            @(posedge clk);
            waited++;
        end
        if (exp_cnt_q.size() != 0)
        begin
            other_errors++;
            $display("%0d results never arrived", exp_cnt_q.size());
        end
        // Quiet stretch to catch stray results
        repeat (8) @(posedge clk);

        $display("Checked %0d results, %0d mismatches, %0d other errors, %0d timeouts",
                 n_checked, mismatches, other_errors, timeouts);
        if (mismatches == 0 && other_errors == 0 && timeouts == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/cnt_testdata.txt ====
// Fields left to right are repeat, gap, opcode, index, amount, expected result
// Gap f means 0 to 3 random idle cycles, repeat n issues a command n+1 times
00_f_1_00_00_0000 00_0_1_01_00_0000 00_0_1_02_00_0000 00_0_1_03_00_0000
00_f_1_04_00_0000 00_0_1_05_00_0000 00_0_1_06_00_0000 00_0_1_07_00_0000
00_f_1_08_00_0000 00_0_1_09_00_0000 00_0_1_0a_00_0000 00_0_1_0b_00_0000
00_f_1_0c_00_0000 00_0_1_0d_00_0000 00_0_1_0e_00_0000 00_0_1_0f_00_0000
00_f_1_10_00_0000 00_0_1_11_00_0000 00_0_1_12_00_0000 00_0_1_13_00_0000
00_f_1_14_00_0000 00_0_1_15_00_0000 00_0_1_16_00_0000 00_0_1_17_00_0000
00_f_1_18_00_0000 00_0_1_19_00_0000 00_0_1_1a_00_0000 00_0_1_1b_00_0000
00_f_1_1c_00_0000 00_0_1_1d_00_0000 00_0_1_1e_00_0000 00_0_1_1f_00_0000
// Running sums on separate counters
00_f_0_01_10_0010 00_f_0_02_20_0020 00_f_0_01_05_0015
00_f_0_03_ff_00ff 00_f_0_02_01_0021 00_f_0_01_0b_0020
// Same counter at distances 1, 2 and 3
00_f_0_04_01_0001 00_0_0_04_02_0003 00_0_0_04_03_0006
00_1_0_04_04_000a 00_2_0_04_05_000f 00_1_0_04_06_0015
00_0_0_04_07_001c 00_0_1_04_00_001c 00_0_0_04_09_0009
// Interleaved counters, back to back
00_f_0_05_01_0001 00_0_0_06_02_0002 00_0_0_05_03_0004
00_0_0_06_04_0006 00_0_0_07_01_0001 00_0_0_05_05_0009
// Saturation at ffff
7f_0_0_08_ff_7f80 7f_f_0_08_ff_ff00 00_f_0_08_80_ff80
00_0_0_08_90_ffff 00_0_0_08_01_ffff 00_2_0_08_ff_ffff
00_0_1_08_00_ffff 00_0_0_08_07_0007
// Clear returns the old value
00_f_1_01_00_0020 00_0_0_01_03_0003 00_3_1_03_00_00ff
00_1_0_03_2a_002a 00_0_1_03_00_002a 00_0_1_03_00_0000
00_f_1_04_00_0009

// ==== sim.f ====
hdl/cnt_pkg.sv
hdl/rmw_if.sv
hdl/cnt_ram.sv
hdl/rmw_hazard.sv
hdl/cnt_update.sv
hdl/cnt_top.sv
tb/tb_clkgen.sv
tb/tb_cnt_top.sv

// ==== Bender.yml ====
package:
  name: cnt_bank

sources:
  - hdl/cnt_pkg.sv
  - hdl/rmw_if.sv
  - hdl/cnt_ram.sv
  - hdl/rmw_hazard.sv
  - hdl/cnt_update.sv
  - hdl/cnt_top.sv
  - target: test
    files:
      - tb/tb_clkgen.sv
      - tb/tb_cnt_top.sv
